//--- include/noc_macros.svh
/*
  Mesh router node parameters: port count, coordinate and payload
  widths, input buffer depth
*/
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Local plus the four mesh neighbours
`define NOC_NUM_PORTS 5

// Bits per mesh axis
`define NOC_COORD_W 3

// Payload widths of the three link classes
`define NOC_REQ_PAYLOAD_W 32
`define NOC_RSP_PAYLOAD_W 16
`define NOC_WIDE_PAYLOAD_W 128

// Entries per input FIFO
`define NOC_IN_DEPTH 2

`endif

//--- source/noc_pkg.sv
/*
  Mesh router shared types: coordinates, flit header, the flits and
  links of the request, response and wide classes, port index
*/
`default_nettype none
`include "noc_macros.svh"

package noc_pkg;

  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // y grows toward north, x grows toward east
  typedef struct packed {
    coord_t x;
    coord_t y;
  } node_id_t;

  typedef struct packed {
    node_id_t dst;
    node_id_t src;
  } hdr_t;

  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_EAST  = 3'd2,
    PORT_SOUTH = 3'd3,
    PORT_WEST  = 3'd4
  } port_e;

  // One bit per port, used for arbiter requests and grants
  typedef logic [`NOC_NUM_PORTS-1:0] port_onehot_t;

  typedef logic [`NOC_REQ_PAYLOAD_W-1:0]  req_data_t;
  typedef logic [`NOC_RSP_PAYLOAD_W-1:0]  rsp_data_t;
  typedef logic [`NOC_WIDE_PAYLOAD_W-1:0] wide_data_t;

  typedef struct packed {
    hdr_t      hdr;
    req_data_t payload;
  } req_flit_t;

  typedef struct packed {
    hdr_t      hdr;
    rsp_data_t payload;
  } rsp_flit_t;

  typedef struct packed {
    hdr_t       hdr;
    wide_data_t payload;
  } wide_flit_t;

  // Forward half of a link, ready runs on its own vector
  typedef struct packed {
    logic      valid;
    req_flit_t flit;
  } req_link_t;

  typedef struct packed {
    logic      valid;
    rsp_flit_t flit;
  } rsp_link_t;

  typedef struct packed {
    logic       valid;
    wide_flit_t flit;
  } wide_link_t;

endpackage

`default_nettype wire

//--- source/noc_in_fifo.sv
/*
  Router input buffer: small circular FIFO with a valid/ready push side
  and a head valid plus pop on the read side
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module noc_in_fifo #(
  parameter type flit_t = logic
) (
  input  wire logic   clk_i,
  input  wire logic   rst_i,
  input  wire logic   valid_i,
  output logic        ready_o,
  input  wire flit_t  data_i,
  output logic        valid_o,
  input  wire logic   pop_i,
  output flit_t       data_o
);

  localparam int DEPTH = `NOC_IN_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  flit_t            mem_q [DEPTH];
  logic             full;
  logic             push;
  logic             pop;

  // Wrap explicitly so a depth that is not a power of two still works
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (count_q == CNT_W'(DEPTH));
  // A pop in this cycle frees the slot, so a full buffer can still take a flit
  assign ready_o = !full || pop_i;
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- source/noc_rr_arbiter.sv
/*
  Round-robin arbiter for one router output, grants the first
  requester at or after a rotating priority pointer
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module noc_rr_arbiter import noc_pkg::*; (
  input  wire logic          clk_i,
  input  wire logic          rst_i,
  input  wire port_onehot_t  req_i,
  input  wire logic          advance_i,
  output port_onehot_t       gnt_o
);

  localparam int NUM = `NOC_NUM_PORTS;

  port_e       ptr_q;
  port_e       gnt_idx;
  logic        found;
  int unsigned idx;

  // Scan from the pointer upward and wrap around
  always_comb begin
    gnt_o   = '0;
    gnt_idx = ptr_q;
    found   = 1'b0;
    idx     = 0;
    for (int off = 0; off < NUM; off++) begin
      idx = (int'(ptr_q) + off) % NUM;
      if (!found && req_i[idx]) begin
        found      = 1'b1;
        gnt_o[idx] = 1'b1;
        gnt_idx    = port_e'(idx);
      end
    end
  end

  // Winner drops to lowest priority once its grant is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= PORT_LOCAL;
    end else if (advance_i && found) begin
      if (gnt_idx == port_e'(NUM - 1)) begin
        ptr_q <= PORT_LOCAL;
      end else begin
        ptr_q <= port_e'(gnt_idx + 1'b1);
      end
    end
  end

endmodule

`default_nettype wire

//--- source/noc_link_router.sv
/*
  Five-port router for one link class: input FIFOs, XY route
  computation, round-robin arbitration per output, crossbar and a
  registered output stage
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module noc_link_router import noc_pkg::*; #(
  parameter type flit_t = req_flit_t
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire node_id_t                    node_id_i,
  input  wire port_onehot_t                in_valid_i,
  output port_onehot_t                     in_ready_o,
  input  wire flit_t [`NOC_NUM_PORTS-1:0]  in_flit_i,
  output port_onehot_t                     out_valid_o,
  input  wire port_onehot_t                out_ready_i,
  output flit_t [`NOC_NUM_PORTS-1:0]       out_flit_o
);

  localparam int NUM = `NOC_NUM_PORTS;

  // FIFO heads
  port_onehot_t           head_valid;
  flit_t [NUM-1:0]        head_flit;
  port_onehot_t           pop;

  // Route result per input, one-hot over outputs
  port_e                  route_dir [NUM];
  port_onehot_t [NUM-1:0] route_req;

  // Per output: request column, grant column, free slot
  port_onehot_t [NUM-1:0] arb_req;
  port_onehot_t [NUM-1:0] arb_gnt;
  port_onehot_t           out_free;
  flit_t [NUM-1:0]        xbar_flit;

  // Output stage
  port_onehot_t           out_valid_q;
  flit_t [NUM-1:0]        out_flit_q;

  // Dimension-ordered routing: x first, then y
  function automatic port_e xy_route(input node_id_t dst, input node_id_t here);
    port_e dir;
    if (dst.x > here.x) begin
      dir = PORT_EAST;
    end else if (dst.x < here.x) begin
      dir = PORT_WEST;
    end else if (dst.y > here.y) begin
      dir = PORT_NORTH;
    end else if (dst.y < here.y) begin
      dir = PORT_SOUTH;
    end else begin
      dir = PORT_LOCAL;
    end
    return dir;
  endfunction

  for (genvar i = 0; i < NUM; i++) begin : gen_in
    noc_in_fifo #(
      .flit_t  ( flit_t )
    ) u_in_fifo (
      .clk_i   ( clk_i         ),
      .rst_i   ( rst_i         ),
      .valid_i ( in_valid_i[i] ),
      .ready_o ( in_ready_o[i] ),
      .data_i  ( in_flit_i[i]  ),
      .valid_o ( head_valid[i] ),
      .pop_i   ( pop[i]        ),
      .data_o  ( head_flit[i]  )
    );
  end

  // A flit that would go back where it came from is sent to local
  always_comb begin
    for (int i = 0; i < NUM; i++) begin
      route_dir[i] = xy_route(head_flit[i].hdr.dst, node_id_i);
      if (route_dir[i] == port_e'(i)) begin
        route_dir[i] = PORT_LOCAL;
      end
      route_req[i] = '0;
      route_req[i][route_dir[i]] = head_valid[i];
    end
  end

  // Output register can load when empty or draining this cycle
  assign out_free = ~out_valid_q | out_ready_i;

  // Transpose into request columns, stalled outputs request nothing
  always_comb begin
    for (int o = 0; o < NUM; o++) begin
      for (int i = 0; i < NUM; i++) begin
        arb_req[o][i] = route_req[i][o] && out_free[o];
      end
    end
  end

  for (genvar o = 0; o < NUM; o++) begin : gen_out
    noc_rr_arbiter u_arbiter (
      .clk_i     ( clk_i       ),
      .rst_i     ( rst_i       ),
      .req_i     ( arb_req[o]  ),
      .advance_i ( |arb_gnt[o] ),
      .gnt_o     ( arb_gnt[o]  )
    );
  end

  // Each input requests one output, so at most one grant pops it
  always_comb begin
    pop = '0;
    for (int o = 0; o < NUM; o++) begin
      pop = pop | arb_gnt[o];
    end
  end

  always_comb begin
    for (int o = 0; o < NUM; o++) begin
      xbar_flit[o] = head_flit[0];
      for (int i = 0; i < NUM; i++) begin
        if (arb_gnt[o][i]) begin
          xbar_flit[o] = head_flit[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q <= '0;
    end else begin
      for (int o = 0; o < NUM; o++) begin
        if (|arb_gnt[o]) begin
          out_valid_q[o] <= 1'b1;
        end else if (out_ready_i[o]) begin
          out_valid_q[o] <= 1'b0;
        end
      end
    end
  end

  // Flit holds while the link stalls
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NUM; o++) begin
      if (|arb_gnt[o]) begin
        out_flit_q[o] <= xbar_flit[o];
      end
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

endmodule

`default_nettype wire

//--- source/noc_nw_router.sv
/*
  Mesh router node with three independent link classes: narrow
  request, response and wide data, each on its own five-port router
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module noc_nw_router import noc_pkg::*; (
  input  wire logic                             clk_i,
  input  wire logic                             rst_i,
  input  wire node_id_t                         node_id_i,
  input  wire req_link_t [`NOC_NUM_PORTS-1:0]   req_i,
  output port_onehot_t                          req_ready_o,
  output req_link_t [`NOC_NUM_PORTS-1:0]        req_o,
  input  wire port_onehot_t                     req_ready_i,
  input  wire rsp_link_t [`NOC_NUM_PORTS-1:0]   rsp_i,
  output port_onehot_t                          rsp_ready_o,
  output rsp_link_t [`NOC_NUM_PORTS-1:0]        rsp_o,
  input  wire port_onehot_t                     rsp_ready_i,
  input  wire wide_link_t [`NOC_NUM_PORTS-1:0]  wide_i,
  output port_onehot_t                          wide_ready_o,
  output wide_link_t [`NOC_NUM_PORTS-1:0]       wide_o,
  input  wire port_onehot_t                     wide_ready_i
);

  localparam int NUM = `NOC_NUM_PORTS;

  port_onehot_t         req_in_valid, req_out_valid;
  port_onehot_t         rsp_in_valid, rsp_out_valid;
  port_onehot_t         wide_in_valid, wide_out_valid;
  req_flit_t [NUM-1:0]  req_in_flit, req_out_flit;
  rsp_flit_t [NUM-1:0]  rsp_in_flit, rsp_out_flit;
  wide_flit_t [NUM-1:0] wide_in_flit, wide_out_flit;

  // Split link structs into valid and flit vectors, and back
  for (genvar p = 0; p < NUM; p++) begin : gen_link
    assign req_in_valid[p]  = req_i[p].valid;
    assign req_in_flit[p]   = req_i[p].flit;
    assign req_o[p].valid   = req_out_valid[p];
    assign req_o[p].flit    = req_out_flit[p];
    assign rsp_in_valid[p]  = rsp_i[p].valid;
    assign rsp_in_flit[p]   = rsp_i[p].flit;
    assign rsp_o[p].valid   = rsp_out_valid[p];
    assign rsp_o[p].flit    = rsp_out_flit[p];
    assign wide_in_valid[p] = wide_i[p].valid;
    assign wide_in_flit[p]  = wide_i[p].flit;
    assign wide_o[p].valid  = wide_out_valid[p];
    assign wide_o[p].flit   = wide_out_flit[p];
  end

  noc_link_router #(
    .flit_t      ( req_flit_t    )
  ) u_req_router (
    .clk_i       ( clk_i         ),
    .rst_i       ( rst_i         ),
    .node_id_i   ( node_id_i     ),
    .in_valid_i  ( req_in_valid  ),
    .in_ready_o  ( req_ready_o   ),
    .in_flit_i   ( req_in_flit   ),
    .out_valid_o ( req_out_valid ),
    .out_ready_i ( req_ready_i   ),
    .out_flit_o  ( req_out_flit  )
  );

  noc_link_router #(
    .flit_t      ( rsp_flit_t    )
  ) u_rsp_router (
    .clk_i       ( clk_i         ),
    .rst_i       ( rst_i         ),
    .node_id_i   ( node_id_i     ),
    .in_valid_i  ( rsp_in_valid  ),
    .in_ready_o  ( rsp_ready_o   ),
    .in_flit_i   ( rsp_in_flit   ),
    .out_valid_o ( rsp_out_valid ),
    .out_ready_i ( rsp_ready_i   ),
    .out_flit_o  ( rsp_out_flit  )
  );

  noc_link_router #(
    .flit_t      ( wide_flit_t    )
  ) u_wide_router (
    .clk_i       ( clk_i          ),
    .rst_i       ( rst_i          ),
    .node_id_i   ( node_id_i      ),
    .in_valid_i  ( wide_in_valid  ),
    .in_ready_o  ( wide_ready_o   ),
    .in_flit_i   ( wide_in_flit   ),
    .out_valid_o ( wide_out_valid ),
    .out_ready_i ( wide_ready_i   ),
    .out_flit_o  ( wide_out_flit  )
  );

endmodule

`default_nettype wire

//--- test/tb_noc_nw_router.sv
/*
  Testbench for the three-class mesh router node with LFSR driven traffic,
  a scoreboard per class, input and output, and back-pressure, class
  independence and round-robin fairness checks
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_macros.svh"

module tb_noc_nw_router import noc_pkg::*; ();

  localparam int NUM         = `NOC_NUM_PORTS;
  localparam int NCLS        = 3;
  localparam int NODE_X      = 3;
  localparam int NODE_Y      = 3;
  localparam int DRAIN_LIMIT = 500;

  logic                  clk_i;
  logic                  rst_i;
  node_id_t              node_id;
  req_link_t [NUM-1:0]   req_in;
  req_link_t [NUM-1:0]   req_out;
  rsp_link_t [NUM-1:0]   rsp_in;
  rsp_link_t [NUM-1:0]   rsp_out;
  wide_link_t [NUM-1:0]  wide_in;
  wide_link_t [NUM-1:0]  wide_out;

  // Class-neutral view with index 0 for request, 1 for response and 2 for wide
  port_onehot_t in_vld  [NCLS];
  port_onehot_t in_acc  [NCLS];
  port_onehot_t in_rdy  [NCLS];
  wide_flit_t   in_flt  [NCLS][NUM];
  port_onehot_t out_vld [NCLS];
  port_onehot_t out_rdy [NCLS];
  wide_flit_t   out_flt [NCLS][NUM];

  logic [31:0]  lfsr_q;
  wide_flit_t   exp_q [NCLS*NUM*NUM][$];
  int           seq [NCLS][NUM];
  logic         held_vld [NCLS][NUM];
  wide_flit_t   held_flt [NCLS][NUM];
  port_onehot_t send_en [NCLS];
  int           rdy_mode [NCLS];
  logic         fair_mode;
  logic         fair_chk;
  logic         seen [NCLS][NUM];
  int           gap [NCLS][NUM];

  noc_nw_router dut0 (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .node_id_i    ( node_id    ),
    .req_i        ( req_in     ),
    .req_ready_o  ( in_rdy[0]  ),
    .req_o        ( req_out    ),
    .req_ready_i  ( out_rdy[0] ),
    .rsp_i        ( rsp_in     ),
    .rsp_ready_o  ( in_rdy[1]  ),
    .rsp_o        ( rsp_out    ),
    .rsp_ready_i  ( out_rdy[1] ),
    .wide_i       ( wide_in    ),
    .wide_ready_o ( in_rdy[2]  ),
    .wide_o       ( wide_out   ),
    .wide_ready_i ( out_rdy[2] )
  );

  // Narrow classes use the low payload bits of the wide view
  always_comb begin
    for (int p = 0; p < NUM; p++) begin
      req_in[p].valid         = in_vld[0][p];
      req_in[p].flit.hdr      = in_flt[0][p].hdr;
      req_in[p].flit.payload  = req_data_t'(in_flt[0][p].payload);
      rsp_in[p].valid         = in_vld[1][p];
      rsp_in[p].flit.hdr      = in_flt[1][p].hdr;
      rsp_in[p].flit.payload  = rsp_data_t'(in_flt[1][p].payload);
      wide_in[p].valid        = in_vld[2][p];
      wide_in[p].flit         = in_flt[2][p];
      out_vld[0][p]           = req_out[p].valid;
      out_flt[0][p].hdr       = req_out[p].flit.hdr;
      out_flt[0][p].payload   = wide_data_t'(req_out[p].flit.payload);
      out_vld[1][p]           = rsp_out[p].valid;
      out_flt[1][p].hdr       = rsp_out[p].flit.hdr;
      out_flt[1][p].payload   = wide_data_t'(rsp_out[p].flit.payload);
      out_vld[2][p]           = wide_out[p].valid;
      out_flt[2][p]           = wide_out[p].flit;
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic value_error(input string msg);
    abort_run($sformatf("FAIL %0t: %s", $time, msg));
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic step_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], step_bit()};
    end
    return v;
  endfunction

  // XY rule corrects x first, then y, and arrives locally
  function automatic int model_route(input node_id_t dst);
    int dx;
    int dy;
    dx = int'(dst.x) - NODE_X;
    dy = int'(dst.y) - NODE_Y;
    if (dx != 0) begin
      return (dx > 0) ? int'(PORT_EAST) : int'(PORT_WEST);
    end
    if (dy != 0) begin
      return (dy > 0) ? int'(PORT_NORTH) : int'(PORT_SOUTH);
    end
    return int'(PORT_LOCAL);
  endfunction

  function automatic int pay_width(input int c);
    case (c)
      0:       return `NOC_REQ_PAYLOAD_W;
      1:       return `NOC_RSP_PAYLOAD_W;
      default: return `NOC_WIDE_PAYLOAD_W;
    endcase
  endfunction

  function automatic int qidx(input int c, input int i, input int o);
    return (c * NUM + i) * NUM + o;
  endfunction

  // Payload bits 15:13 hold the input port, 12:0 the sequence number
  function automatic wide_flit_t new_flit(input int c, input int p);
    wide_flit_t  f;
    node_id_t    dst;
    logic [31:0] r;
    f = '0;
    do begin
      r     = fair_mode ? (32'd4 + rand_bits(2)) : rand_bits(3);
      dst.x = r[2:0];
      r     = rand_bits(3);
      dst.y = r[2:0];
    end while (model_route(dst) == p);
    r                = rand_bits(6);
    f.hdr.dst        = dst;
    f.hdr.src        = r[5:0];
    f.payload[15:13] = 3'(p);
    f.payload[12:0]  = 13'(seq[c][p]);
    for (int b = 16; b < pay_width(c); b++) begin
      f.payload[b] = step_bit();
    end
    seq[c][p]++;
    return f;
  endfunction

  function automatic logic classes_idle(input logic [2:0] mask);
    for (int c = 0; c < NCLS; c++) begin
      if (mask[c]) begin
        if ((in_vld[c] & ~in_acc[c]) != '0) begin
          return 1'b0;
        end
        for (int k = 0; k < NUM * NUM; k++) begin
          if (exp_q[c * NUM * NUM + k].size() != 0) begin
            return 1'b0;
          end
        end
      end
    end
    return 1'b1;
  endfunction

  // A stalled output must hold valid and flit
  task automatic check_held();
    for (int c = 0; c < NCLS; c++) begin
      for (int o = 0; o < NUM; o++) begin
        if (held_vld[c][o]) begin
          assert (out_vld[c][o] && out_flt[c][o] == held_flt[c][o]) else
            value_error($sformatf("class %0d output %0d changed while stalled", c, o));
        end
      end
    end
  endtask

  // An unaccepted flit stays on the link unchanged
  task automatic drive_inputs();
    for (int c = 0; c < NCLS; c++) begin
      for (int p = 0; p < NUM; p++) begin
        if (!(in_vld[c][p] && !in_acc[c][p])) begin
          in_vld[c][p] = 1'b0;
          if (send_en[c][p] && (fair_mode || step_bit())) begin
            in_flt[c][p] = new_flit(c, p);
            in_vld[c][p] = 1'b1;
          end
        end
      end
      in_acc[c] = '0;
      for (int o = 0; o < NUM; o++) begin
        case (rdy_mode[c])
          1:       out_rdy[c][o] = 1'b1;
          2:       out_rdy[c][o] = 1'b0;
          default: out_rdy[c][o] = (rand_bits(2) != 32'd0);
        endcase
      end
    end
  endtask

  task automatic update_fairness(input int c, input int win);
    for (int j = 0; j < NUM; j++) begin
      if (seen[c][j] && j != win) begin
        gap[c][j]++;
        assert (gap[c][j] < NUM) else
          value_error($sformatf("class %0d input %0d starved on east output", c, j));
      end
    end
    gap[c][win]  = 0;
    seen[c][win] = 1'b1;
  endtask

  task automatic check_delivery(input int c, input int o);
    wide_flit_t got;
    wide_flit_t exp_f;
    int         src_in;
    int         q;
    got    = out_flt[c][o];
    src_in = int'(got.payload[15:13]);
    assert (src_in < NUM) else
      value_error($sformatf("class %0d output %0d bad input tag %0d", c, o, src_in));
    assert (model_route(got.hdr.dst) == o) else
      value_error($sformatf("class %0d flit to %h left by port %0d", c, got.hdr.dst, o));
    q = qidx(c, src_in, o);
    assert (exp_q[q].size() > 0) else
      value_error($sformatf("class %0d output %0d unexpected flit %h", c, o, got));
    exp_f = exp_q[q].pop_front();
    assert (got == exp_f) else
      value_error($sformatf("class %0d output %0d got %h expected %h", c, o, got, exp_f));
    if (fair_chk && o == int'(PORT_EAST)) begin
      update_fairness(c, src_in);
    end
  endtask

  // Sampled mid-cycle, so every value is settled until the next rising edge
  task automatic sample_transfers();
    for (int c = 0; c < NCLS; c++) begin
      for (int p = 0; p < NUM; p++) begin
        if (in_vld[c][p] && in_rdy[c][p]) begin
          exp_q[qidx(c, p, model_route(in_flt[c][p].hdr.dst))].push_back(in_flt[c][p]);
          in_acc[c][p] = 1'b1;
        end
      end
      for (int o = 0; o < NUM; o++) begin
        held_vld[c][o] = out_vld[c][o] && !out_rdy[c][o];
        held_flt[c][o] = out_flt[c][o];
        if (out_vld[c][o] && out_rdy[c][o]) begin
          check_delivery(c, o);
        end
      end
    end
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    check_held();
    drive_inputs();
    #1;
    sample_transfers();
  endtask

  task automatic wait_drain(input logic [2:0] mask, input string what);
    int cycles;
    cycles = 0;
    while (!classes_idle(mask)) begin
      if (cycles >= DRAIN_LIMIT) begin
        abort_run($sformatf("Timeout: %s did not drain in %0d cycles", what, DRAIN_LIMIT));
      end
      run_cycle();
      cycles++;
    end
  endtask

  initial begin
    lfsr_q    = 32'h667e;
    rst_i     = 1'b1;
    node_id.x = 3'(NODE_X);
    node_id.y = 3'(NODE_Y);
    fair_mode = 1'b0;
    fair_chk  = 1'b0;
    for (int c = 0; c < NCLS; c++) begin
      in_vld[c]   = '0;
      in_acc[c]   = '0;
      out_rdy[c]  = '0;
      send_en[c]  = '0;
      rdy_mode[c] = 0;
      for (int p = 0; p < NUM; p++) begin
        in_flt[c][p]   = '0;
        seq[c][p]      = 0;
        held_vld[c][p] = 1'b0;
        held_flt[c][p] = '0;
        seen[c][p]     = 1'b0;
        gap[c][p]      = 0;
      end
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    for (int c = 0; c < NCLS; c++) begin
      assert (out_vld[c] == '0) else value_error($sformatf("class %0d valid after reset", c));
      assert (in_rdy[c] == '1) else value_error($sformatf("class %0d not ready after reset", c));
    end

    // Mixed random traffic with random back-pressure
    for (int c = 0; c < NCLS; c++) begin
      send_en[c] = '1;
    end
    repeat (600) run_cycle();
    for (int c = 0; c < NCLS; c++) begin
      send_en[c] = '0;
    end
    wait_drain(3'b111, "random traffic");

    // Wide outputs stalled while the narrow classes keep moving
    rdy_mode[2] = 2;
    for (int c = 0; c < NCLS; c++) begin
      send_en[c] = '1;
    end
    repeat (200) run_cycle();
    for (int c = 0; c < NCLS; c++) begin
      send_en[c] = '0;
    end
    wait_drain(3'b011, "request and response traffic with wide outputs stalled");
    rdy_mode[2] = 0;
    wait_drain(3'b111, "wide traffic after the stall");

    // Four inputs compete for east with every output ready
    fair_mode = 1'b1;
    fair_chk  = 1'b1;
    for (int c = 0; c < NCLS; c++) begin
      rdy_mode[c] = 1;
      send_en[c]  = 5'b11011;
    end
    repeat (300) run_cycle();
    fair_chk  = 1'b0;
    fair_mode = 1'b0;
    for (int c = 0; c < NCLS; c++) begin
      send_en[c] = '0;
    end
    wait_drain(3'b111, "fairness traffic");

    // Any flit that still shows up has no queue entry left
    repeat (4 * NUM) run_cycle();

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
source/noc_pkg.sv
source/noc_in_fifo.sv
source/noc_rr_arbiter.sv
source/noc_link_router.sv
source/noc_nw_router.sv
test/tb_noc_nw_router.sv

//--- Makefile
# Verilator build and run of the mesh router testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_noc_nw_router
FILELIST  := list.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
